// File: project.f
+incdir+include
hw/nanorv_pkg.sv
hw/nanorv_ctrl_if.sv
hw/nanorv_fetch.sv
hw/nanorv_decoder.sv
hw/nanorv_regfile.sv
hw/nanorv_alu.sv
hw/nanorv_lsu.sv
hw/nanorv_core.sv
dv/tb_nanorv.sv

// File: Makefile
TOP = tb_nanorv

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: dv/tb_nanorv.sv
`timescale 1ns/100ps
`include "nanorv_config.svh"

module tb_nanorv
   import nanorv_pkg::*;
();

   localparam int PROG_LEN       = 64;
   localparam int CLK_HALF       = 4;
   localparam int RESET_CYCLES   = 4;
   localparam int HOLD_CYCLES    = 6;
   // At most PROG_LEN + 1 retired words, plus reset, hold and margin
   localparam int TIMEOUT_CYCLES = 4 * (PROG_LEN + 1) + 40;

   // Slot kinds for the program generator
   localparam int K_OP     = 0;
   localparam int K_OP_IMM = 1;
   localparam int K_LUI    = 2;
   localparam int K_AUIPC  = 3;
   localparam int K_BRANCH = 4;
   localparam int K_JAL    = 5;
   localparam int K_LW     = 6;
   localparam int K_SW     = 7;
   localparam int K_JBASE  = 8;
   localparam int K_JALR   = 9;

   logic        clk;
   logic        arst_n;
   logic [31:0] imem_addr;
   logic [31:0] imem_rdata;
   logic [31:0] dmem_addr;
   logic [31:0] dmem_wdata;
   logic        dmem_we;
   logic        dmem_re;
   logic [31:0] dmem_rdata;
   logic        halted;

   logic [31:0] imem [0:127];
   logic [31:0] dmem [`NANORV_DMEM_WORDS];
   int          slot_kind [PROG_LEN];
   logic [31:0] rng_state = 32'haa8b;
   int          cycle_count = 0;
   int          store_strobes = 0;

   // Reference model state
   logic [31:0] m_regs [`NANORV_NUM_REGS];
   logic [31:0] m_mem [`NANORV_DMEM_WORDS];
   logic [31:0] trace [0:127];
   logic        trace_ld [0:127];
   logic        trace_st [0:127];
   logic [31:0] st_addr [0:127];
   logic [31:0] st_data [0:127];
   int          trace_len;
   int          st_count;

   nanorv_core uut (
      .clk        (clk),
      .arst_n     (arst_n),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_we    (dmem_we),
      .dmem_re    (dmem_re),
      .dmem_rdata (dmem_rdata),
      .halted     (halted)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_HALF) clk = ~clk;
   end

   // Combinational memory reads
   assign imem_rdata = imem[imem_addr[8:2]];
   assign dmem_rdata = dmem[dmem_addr[7:2]];

   // Store commits at the closing edge
   always @(posedge clk) begin
      if (dmem_we) begin
         dmem[dmem_addr[7:2]] <= dmem_wdata;
         store_strobes <= store_strobes + 1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
         stop_with_error("Timeout, the core never reached the end of the program");
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Initial data memory content mixing every address bit
   function automatic logic [31:0] fill_word(input int idx);
      return (32'(idx) * 32'h9e37_79b9) ^ 32'h3c5a_0f00;
   endfunction

   // Forward hop of at most 8 slots and never onto a JALR
   function automatic int forward_target(input int idx);
      int          span;
      int          tgt;
      logic [31:0] r;
      span = PROG_LEN - idx;
      if (span > 8)
         span = 8;
      r = next_random();
      tgt = idx + 1 + int'(r % 32'(span));
      // Skipping the base ADDI would leave a stale JALR base
      if (tgt < PROG_LEN && slot_kind[tgt] == K_JALR)
         tgt++;
      return tgt;
   endfunction

   task automatic stop_with_error(input string what);
      $display("%s", what);
      $display("Simulation FAILED");
      $fatal(1, "Run aborted");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1, "Check %s failed", name);
      end
   endtask

   task automatic build_program();
      int          i;
      int          tgt;
      logic [31:0] r;
      logic [31:0] s;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [4:0]  base_reg;
      logic [11:0] simm;
      logic [12:0] boff;
      logic [20:0] joff;
      for (i = 0; i < 128; i++)
         imem[i] = 32'h0;
      // Pass 1 picks slot kinds and a JALR takes two slots
      i = 0;
      base_reg = 5'd1;
      while (i < PROG_LEN) begin
         r = next_random();
         if (i == 0) begin
            // No memory strobe on the very first word
            slot_kind[i] = K_LUI;
         end else if (r[3:0] == 4'd15 && i < PROG_LEN - 1) begin
            slot_kind[i] = K_JBASE;
            slot_kind[i + 1] = K_JALR;
            i++;
         end else begin
            case (r[3:0])
               4'd4, 4'd5, 4'd6: slot_kind[i] = K_OP_IMM;
               4'd7:             slot_kind[i] = K_LUI;
               4'd8:             slot_kind[i] = K_AUIPC;
               4'd9, 4'd10:      slot_kind[i] = K_BRANCH;
               4'd11:            slot_kind[i] = K_JAL;
               4'd12:            slot_kind[i] = K_LW;
               4'd13, 4'd14:     slot_kind[i] = K_SW;
               default:          slot_kind[i] = K_OP;
            endcase
         end
         i++;
      end
      // Pass 2 fills in the encodings
      for (i = 0; i < PROG_LEN; i++) begin
         r = next_random();
         s = next_random();
         case (slot_kind[i])
            K_OP: begin
               f7 = 7'h00;
               case (r[31:28])
                  4'd0, 4'd9:  f3 = 3'b000;
                  4'd1, 4'd10: begin
                     f3 = 3'b000;
                     f7 = 7'h20;
                  end
                  4'd2, 4'd11: f3 = 3'b001;
                  4'd3, 4'd12: f3 = 3'b010;
                  4'd4, 4'd13: f3 = 3'b100;
                  4'd5, 4'd14: f3 = 3'b101;
                  4'd6, 4'd15: begin
                     f3 = 3'b101;
                     f7 = 7'h20;
                  end
                  4'd7:        f3 = 3'b110;
                  default:     f3 = 3'b111;
               endcase
               imem[i] = {f7, r[24:20], r[19:15], f3, r[11:7], OPC_OP};
            end
            K_OP_IMM: begin
               case (r[31:29])
                  3'd0, 3'd5: f3 = 3'b000;
                  3'd1, 3'd6: f3 = 3'b010;
                  3'd2, 3'd7: f3 = 3'b100;
                  3'd3:       f3 = 3'b110;
                  default:    f3 = 3'b111;
               endcase
               imem[i] = {s[11:0], r[19:15], f3, r[11:7], OPC_OP_IMM};
            end
            K_LUI:   imem[i] = {s[31:12], r[11:7], OPC_LUI};
            K_AUIPC: imem[i] = {s[31:12], r[11:7], OPC_AUIPC};
            K_BRANCH: begin
               tgt = forward_target(i);
               boff = 13'((tgt - i) * 4);
               // EQ, NE, LT, GE
               f3 = {r[31], 1'b0, r[30]};
               imem[i] = {boff[12], boff[10:5], r[24:20], r[19:15], f3, boff[4:1], boff[11],
                          OPC_BRANCH};
            end
            K_JAL: begin
               tgt = forward_target(i);
               joff = 21'((tgt - i) * 4);
               imem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], r[11:7], OPC_JAL};
            end
            K_LW: imem[i] = {4'b0, s[5:0], 2'b00, 5'd0, 3'b010, r[11:7], OPC_LOAD};
            K_SW: begin
               simm = {4'b0, s[5:0], 2'b00};
               imem[i] = {simm[11:5], r[24:20], 5'd0, 3'b010, simm[4:0], OPC_STORE};
            end
            K_JBASE: begin
               // ADDI loads the absolute target for the JALR that follows
               tgt = forward_target(i + 1);
               base_reg = (r[11:7] == 5'd0) ? 5'd1 : r[11:7];
               imem[i] = {12'(tgt * 4), 5'd0, 3'b000, base_reg, OPC_OP_IMM};
            end
            default: imem[i] = {12'd0, base_reg, 3'b000, r[11:7], OPC_JALR};
         endcase
      end
      // All-zero word is illegal and ends the program
      imem[PROG_LEN] = 32'h0;
   endtask

   // Executes the program by the RV32I rules and records PC trace and stores
   task automatic run_model();
      logic [31:0] pc;
      logic [31:0] next_pc;
      logic [31:0] insn;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] imm_b;
      logic [31:0] imm_j;
      logic [31:0] addr;
      logic [31:0] wval;
      logic        wen;
      logic        taken;
      logic        stop;
      for (int i = 0; i < `NANORV_NUM_REGS; i++)
         m_regs[i] = 32'h0;
      for (int i = 0; i < `NANORV_DMEM_WORDS; i++)
         m_mem[i] = fill_word(i);
      pc = `NANORV_RESET_PC;
      stop = 1'b0;
      trace_len = 0;
      st_count = 0;
      while (!stop) begin
         insn = imem[pc[8:2]];
         trace[trace_len] = pc;
         trace_ld[trace_len] = 1'b0;
         trace_st[trace_len] = 1'b0;
         a = m_regs[insn[19:15]];
         b = m_regs[insn[24:20]];
         imm_i = {{20{insn[31]}}, insn[31:20]};
         imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
         imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
         imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
         next_pc = pc + 32'd4;
         wen = 1'b0;
         wval = 32'h0;
         case (insn[6:0])
            OPC_LUI: begin
               wen = 1'b1;
               wval = {insn[31:12], 12'b0};
            end
            OPC_AUIPC: begin
               wen = 1'b1;
               wval = pc + {insn[31:12], 12'b0};
            end
            OPC_JAL: begin
               wen = 1'b1;
               wval = pc + 32'd4;
               next_pc = pc + imm_j;
            end
            OPC_JALR: begin
               wen = 1'b1;
               wval = pc + 32'd4;
               next_pc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
               case (insn[14:12])
                  3'b000:  taken = (a == b);
                  3'b001:  taken = (a != b);
                  3'b100:  taken = ($signed(a) < $signed(b));
                  default: taken = ($signed(a) >= $signed(b));
               endcase
               if (taken)
                  next_pc = pc + imm_b;
            end
            OPC_LOAD: begin
               addr = a + imm_i;
               wen = 1'b1;
               wval = m_mem[addr[7:2]];
               trace_ld[trace_len] = 1'b1;
            end
            OPC_STORE: begin
               addr = a + imm_s;
               m_mem[addr[7:2]] = b;
               st_addr[st_count] = addr;
               st_data[st_count] = b;
               st_count++;
               trace_st[trace_len] = 1'b1;
            end
            OPC_OP_IMM: begin
               wen = 1'b1;
               case (insn[14:12])
                  3'b000:  wval = a + imm_i;
                  3'b010:  wval = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
                  3'b100:  wval = a ^ imm_i;
                  3'b110:  wval = a | imm_i;
                  default: wval = a & imm_i;
               endcase
            end
            OPC_OP: begin
               wen = 1'b1;
               case ({insn[30], insn[14:12]})
                  4'b0000: wval = a + b;
                  4'b1000: wval = a - b;
                  4'b0001: wval = a << b[4:0];
                  4'b0010: wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  4'b0100: wval = a ^ b;
                  4'b0101: wval = a >> b[4:0];
                  4'b1101: wval = $unsigned($signed(a) >>> b[4:0]);
                  4'b0110: wval = a | b;
                  default: wval = a & b;
               endcase
            end
            // Anything else halts and the PC stays on it
            default: stop = 1'b1;
         endcase
         if (wen && insn[11:7] != 5'd0)
            m_regs[insn[11:7]] = wval;
         if (!stop)
            pc = next_pc;
         trace_len++;
      end
   endtask

   initial begin
      int seen_stores;
      arst_n = 1'b0;
      seen_stores = 0;
      build_program();
      for (int i = 0; i < `NANORV_DMEM_WORDS; i++)
         dmem[i] = fill_word(i);
      run_model();

      repeat (RESET_CYCLES) @(posedge clk);
      #1 arst_n = 1'b1;

      // First cycle out of reset
      @(negedge clk);
      check_value("reset_pc", `NANORV_RESET_PC, imem_addr);
      check_value("reset_dmem_we", 32'd0, 32'(dmem_we));
      check_value("reset_dmem_re", 32'd0, 32'(dmem_re));
      check_value("reset_halted", 32'd0, 32'(halted));

      // One retired word per cycle with outputs checked mid-cycle
      for (int k = 0; k < trace_len; k++) begin
         if (k > 0)
            @(negedge clk);
         check_value("halted_while_running", 32'd0, 32'(halted));
         check_value($sformatf("pc_trace_%0d", k), trace[k], imem_addr);
         check_value($sformatf("dmem_re_%0d", k), 32'(trace_ld[k]), 32'(dmem_re));
         check_value($sformatf("dmem_we_%0d", k), 32'(trace_st[k]), 32'(dmem_we));
         if (trace_st[k]) begin
            check_value("store_addr", st_addr[seen_stores], dmem_addr);
            check_value("store_data", st_data[seen_stores], dmem_wdata);
            seen_stores++;
         end
      end

      // Core must freeze on the illegal word
      for (int k = 0; k < HOLD_CYCLES; k++) begin
         @(negedge clk);
         check_value("halted_after_illegal", 32'd1, 32'(halted));
         check_value("pc_hold", trace[trace_len - 1], imem_addr);
         check_value("dmem_we_after_halt", 32'd0, 32'(dmem_we));
         check_value("dmem_re_after_halt", 32'd0, 32'(dmem_re));
      end

      check_value("store_count", 32'(st_count), 32'(store_strobes));
      for (int i = 0; i < `NANORV_DMEM_WORDS; i++)
         check_value($sformatf("dmem_word_%0d", i), m_mem[i], dmem[i]);
      // Architectural registers at halt
      for (int i = 1; i < `NANORV_NUM_REGS; i++)
         check_value($sformatf("reg_x%0d", i), m_regs[i], uut.u_regfile.regs[i]);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: hw/nanorv_core.sv
`timescale 1ns/100ps
`include "nanorv_config.svh"

module nanorv_core (
   input  logic                    clk,
   input  logic                    arst_n,
   // Instruction fetch port
   output logic [`NANORV_XLEN-1:0] imem_addr,
   input  logic [31:0]             imem_rdata,
   // Data memory port
   output logic [`NANORV_XLEN-1:0] dmem_addr,
   output logic [`NANORV_XLEN-1:0] dmem_wdata,
   output logic                    dmem_we,
   output logic                    dmem_re,
   input  logic [`NANORV_XLEN-1:0] dmem_rdata,
   output logic                    halted
);

   logic [`NANORV_XLEN-1:0] pc;
   logic [`NANORV_XLEN-1:0] pc_plus4;
   logic [`NANORV_XLEN-1:0] alu_result;
   logic [`NANORV_XLEN-1:0] rs1_data;
   logic [`NANORV_XLEN-1:0] rs2_data;
   logic [`NANORV_XLEN-1:0] rd_wdata;
   logic                    rf_write;

   // Decoded controls shared by all stages
   nanorv_ctrl_if ctrl ();

   assign imem_addr = pc;

   // Register writes blocked once halted
   assign rf_write = ctrl.regfile_write & ~halted;

   nanorv_fetch u_fetch (
      .clk        (clk),
      .arst_n     (arst_n),
      .ctrl       (ctrl.fetch),
      .alu_result (alu_result),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .pc         (pc),
      .pc_plus4   (pc_plus4),
      .halted     (halted)
   );

   nanorv_decoder u_decoder (
      .instruction (imem_rdata),
      .ctrl        (ctrl.dec)
   );

   // Indices come from the decoder fields
   nanorv_regfile u_regfile (
      .clk      (clk),
      .arst_n   (arst_n),
      .rs1_addr (ctrl.rs1),
      .rs2_addr (ctrl.rs2),
      .rd_addr  (ctrl.rd),
      .write    (rf_write),
      .wdata    (rd_wdata),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   nanorv_alu u_alu (
      .ctrl     (ctrl.exec),
      .pc       (pc),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .result   (alu_result)
   );

   nanorv_lsu u_lsu (
      .ctrl       (ctrl.lsu),
      .halted     (halted),
      .alu_result (alu_result),
      .rs2_data   (rs2_data),
      .pc_plus4   (pc_plus4),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_we    (dmem_we),
      .dmem_re    (dmem_re),
      .dmem_rdata (dmem_rdata),
      .rd_wdata   (rd_wdata)
   );

endmodule

// File: hw/nanorv_lsu.sv
`timescale 1ns/100ps
`include "nanorv_config.svh"

module nanorv_lsu
   import nanorv_pkg::*;
(
   nanorv_ctrl_if.lsu              ctrl,
   input  logic                    halted,
   input  logic [`NANORV_XLEN-1:0] alu_result,
   input  logic [`NANORV_XLEN-1:0] rs2_data,
   input  logic [`NANORV_XLEN-1:0] pc_plus4,
   output logic [`NANORV_XLEN-1:0] dmem_addr,
   output logic [`NANORV_XLEN-1:0] dmem_wdata,
   output logic                    dmem_we,
   output logic                    dmem_re,
   input  logic [`NANORV_XLEN-1:0] dmem_rdata,
   output logic [`NANORV_XLEN-1:0] rd_wdata
);

   // Address is rs1 + offset from the ALU
   assign dmem_addr  = alu_result;
   assign dmem_wdata = rs2_data;

   // No memory traffic once halted
   assign dmem_we = ctrl.datamem_write & ~halted;
   assign dmem_re = ctrl.datamem_read & ~halted;

   // Write-back source mux
   always_comb begin
      case (ctrl.regfile_source_sel)
         RF_SRC_MEM:      rd_wdata = dmem_rdata;
         RF_SRC_PC_PLUS4: rd_wdata = pc_plus4;
         default:         rd_wdata = alu_result;
      endcase
   end

   // Strobes exclusive, address word-aligned and inside the data memory
   always_comb begin
      a_strobe_excl : assert final (!(dmem_we && dmem_re));
      a_addr_legal : assert final (!(dmem_we || dmem_re) ||
         ((dmem_addr[1:0] == 2'b00) && (dmem_addr < `NANORV_XLEN'(`NANORV_DMEM_WORDS * 4))));
   end

endmodule

// File: hw/nanorv_alu.sv
`timescale 1ns/100ps
`include "nanorv_config.svh"

module nanorv_alu
   import nanorv_pkg::*;
(
   nanorv_ctrl_if.exec             ctrl,
   input  logic [`NANORV_XLEN-1:0] pc,
   input  logic [`NANORV_XLEN-1:0] rs1_data,
   input  logic [`NANORV_XLEN-1:0] rs2_data,
   output logic [`NANORV_XLEN-1:0] result
);

   logic [`NANORV_XLEN-1:0] op_a;
   logic [`NANORV_XLEN-1:0] op_b;
   logic [4:0]              shamt;
   logic                    lt_signed;

   // Operand muxes
   assign op_a = (ctrl.alu_porta_sel == PORTA_PC) ? pc : rs1_data;
   assign op_b = (ctrl.alu_portb_sel == PORTB_IMM) ? ctrl.imm : rs2_data;

   // Shift amount from low bits of operand B
   assign shamt = op_b[4:0];
   // Signed compare feeding SLT
   assign lt_signed = ($signed(op_a) < $signed(op_b));

   always_comb begin
      case (ctrl.alu_op_sel)
         ALU_ADD:    result = op_a + op_b;
         ALU_SUB:    result = op_a - op_b;
         ALU_SLL:    result = op_a << shamt;
         ALU_SLT:    result = {{(`NANORV_XLEN-1){1'b0}}, lt_signed};
         ALU_XOR:    result = op_a ^ op_b;
         ALU_OR:     result = op_a | op_b;
         ALU_AND:    result = op_a & op_b;
         ALU_SRL:    result = op_a >> shamt;
         // Arithmetic shift keeps the sign
         ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
         // LUI passes the U immediate through
         ALU_PASS_B: result = op_b;
         default:    result = '0;
      endcase
   end

endmodule

// File: hw/nanorv_regfile.sv
`timescale 1ns/100ps
`include "nanorv_config.svh"

module nanorv_regfile (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic [$clog2(`NANORV_NUM_REGS)-1:0] rs1_addr,
   input  logic [$clog2(`NANORV_NUM_REGS)-1:0] rs2_addr,
   input  logic [$clog2(`NANORV_NUM_REGS)-1:0] rd_addr,
   input  logic                                write,
   input  logic [`NANORV_XLEN-1:0]             wdata,
   output logic [`NANORV_XLEN-1:0]             rs1_data,
   output logic [`NANORV_XLEN-1:0]             rs2_data
);

   logic [`NANORV_XLEN-1:0] regs [`NANORV_NUM_REGS];

   // Whole array cleared at reset and x0 never written
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `NANORV_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (write && (rd_addr != '0)) begin
         regs[rd_addr] <= wdata;
      end
   end

   // Asynchronous reads
   assign rs1_data = regs[rs1_addr];
   assign rs2_data = regs[rs2_addr];

endmodule

// File: hw/nanorv_decoder.sv
`timescale 1ns/100ps
`include "nanorv_config.svh"

module nanorv_decoder
   import nanorv_pkg::*;
(
   input  logic [31:0] instruction,
   nanorv_ctrl_if.dec  ctrl
);

   localparam int REG_AW = $clog2(`NANORV_NUM_REGS);

   logic [6:0]              opcode;
   logic [2:0]              funct3;
   logic [6:0]              funct7;
   logic [`NANORV_XLEN-1:0] imm_i;
   logic [`NANORV_XLEN-1:0] imm_s;
   logic [`NANORV_XLEN-1:0] imm_b;
   logic [`NANORV_XLEN-1:0] imm_u;
   logic [`NANORV_XLEN-1:0] imm_j;

   assign opcode = instruction[6:0];
   assign funct3 = instruction[14:12];
   assign funct7 = instruction[31:25];

   // Register indices straight from the encoding
   assign ctrl.rd  = instruction[7 +: REG_AW];
   assign ctrl.rs1 = instruction[15 +: REG_AW];
   assign ctrl.rs2 = instruction[20 +: REG_AW];

   // Immediates per format, sign bit is always instruction[31]
   assign imm_i = {{(`NANORV_XLEN-12){instruction[31]}}, instruction[31:20]};
   assign imm_s = {{(`NANORV_XLEN-12){instruction[31]}}, instruction[31:25], instruction[11:7]};
   assign imm_b = {{(`NANORV_XLEN-12){instruction[31]}}, instruction[7], instruction[30:25],
                   instruction[11:8], 1'b0};
   assign imm_u = {instruction[31:12], 12'b0};
   assign imm_j = {{(`NANORV_XLEN-20){instruction[31]}}, instruction[19:12], instruction[20],
                   instruction[30:21], 1'b0};

   always_comb begin
      // Safe selects, no side effects
      ctrl.illegal_instruction = 1'b0;
      ctrl.pc_next_sel         = PC_NEXT_PLUS4;
      ctrl.branch_cond         = BR_EQ;
      ctrl.alu_op_sel          = ALU_NOP;
      ctrl.alu_porta_sel       = PORTA_RS1;
      ctrl.alu_portb_sel       = PORTB_RS2;
      ctrl.regfile_source_sel  = RF_SRC_ALU;
      ctrl.regfile_write       = 1'b0;
      ctrl.datamem_read        = 1'b0;
      ctrl.datamem_write       = 1'b0;
      ctrl.imm                 = '0;
      case (opcode)
         OPC_LUI: begin
            ctrl.alu_op_sel    = ALU_PASS_B;
            ctrl.alu_portb_sel = PORTB_IMM;
            ctrl.imm           = imm_u;
            ctrl.regfile_write = 1'b1;
         end
         OPC_AUIPC: begin
            ctrl.alu_op_sel    = ALU_ADD;
            ctrl.alu_porta_sel = PORTA_PC;
            ctrl.alu_portb_sel = PORTB_IMM;
            ctrl.imm           = imm_u;
            ctrl.regfile_write = 1'b1;
         end
         OPC_JAL: begin
            // Target from the fetch adder, link value is PC+4
            ctrl.pc_next_sel        = PC_NEXT_JAL;
            ctrl.imm                = imm_j;
            ctrl.regfile_source_sel = RF_SRC_PC_PLUS4;
            ctrl.regfile_write      = 1'b1;
         end
         OPC_JALR: begin
            if (funct3 == 3'b000) begin
               ctrl.pc_next_sel        = PC_NEXT_JALR;
               ctrl.alu_op_sel         = ALU_ADD;
               ctrl.alu_portb_sel      = PORTB_IMM;
               ctrl.imm                = imm_i;
               ctrl.regfile_source_sel = RF_SRC_PC_PLUS4;
               ctrl.regfile_write      = 1'b1;
            end else begin
               ctrl.illegal_instruction = 1'b1;
            end
         end
         OPC_BRANCH: begin
            ctrl.imm = imm_b;
            case (funct3)
               3'b000:  ctrl.branch_cond = BR_EQ;
               3'b001:  ctrl.branch_cond = BR_NE;
               3'b100:  ctrl.branch_cond = BR_LT;
               3'b101:  ctrl.branch_cond = BR_GE;
               default: ctrl.illegal_instruction = 1'b1;
            endcase
            if (!ctrl.illegal_instruction)
               ctrl.pc_next_sel = PC_NEXT_BRANCH;
         end
         OPC_LOAD, OPC_STORE: begin
            // Word access only
            if (funct3 == 3'b010) begin
               ctrl.alu_op_sel         = ALU_ADD;
               ctrl.alu_portb_sel      = PORTB_IMM;
               ctrl.imm                = (opcode == OPC_LOAD) ? imm_i : imm_s;
               ctrl.datamem_read       = (opcode == OPC_LOAD);
               ctrl.datamem_write      = (opcode == OPC_STORE);
               ctrl.regfile_source_sel = RF_SRC_MEM;
               ctrl.regfile_write      = (opcode == OPC_LOAD);
            end else begin
               ctrl.illegal_instruction = 1'b1;
            end
         end
         OPC_OP_IMM: begin
            ctrl.alu_portb_sel = PORTB_IMM;
            ctrl.imm           = imm_i;
            case (funct3)
               3'b000:  ctrl.alu_op_sel = ALU_ADD;
               3'b010:  ctrl.alu_op_sel = ALU_SLT;
               3'b100:  ctrl.alu_op_sel = ALU_XOR;
               3'b110:  ctrl.alu_op_sel = ALU_OR;
               3'b111:  ctrl.alu_op_sel = ALU_AND;
               default: ctrl.illegal_instruction = 1'b1;
            endcase
            ctrl.regfile_write = !ctrl.illegal_instruction;
         end
         OPC_OP: begin
            case ({funct7, funct3})
               {7'h00, 3'b000}: ctrl.alu_op_sel = ALU_ADD;
               {7'h20, 3'b000}: ctrl.alu_op_sel = ALU_SUB;
               {7'h00, 3'b001}: ctrl.alu_op_sel = ALU_SLL;
               {7'h00, 3'b010}: ctrl.alu_op_sel = ALU_SLT;
               {7'h00, 3'b100}: ctrl.alu_op_sel = ALU_XOR;
               {7'h00, 3'b101}: ctrl.alu_op_sel = ALU_SRL;
               {7'h20, 3'b101}: ctrl.alu_op_sel = ALU_SRA;
               {7'h00, 3'b110}: ctrl.alu_op_sel = ALU_OR;
               {7'h00, 3'b111}: ctrl.alu_op_sel = ALU_AND;
               default:         ctrl.illegal_instruction = 1'b1;
            endcase
            ctrl.regfile_write = !ctrl.illegal_instruction;
         end
         // Unknown opcode, selects keep their safe values
         default: ctrl.illegal_instruction = 1'b1;
      endcase
   end

   // An illegal word must never commit state anywhere in the core
   always_comb begin
      a_illegal_no_write : assert final
         (!(ctrl.illegal_instruction && (ctrl.regfile_write || ctrl.datamem_write)));
   end

endmodule

// File: hw/nanorv_fetch.sv
`timescale 1ns/100ps
`include "nanorv_config.svh"

module nanorv_fetch
   import nanorv_pkg::*;
(
   input  logic                    clk,
   input  logic                    arst_n,
   nanorv_ctrl_if.fetch            ctrl,
   input  logic [`NANORV_XLEN-1:0] alu_result,
   input  logic [`NANORV_XLEN-1:0] rs1_data,
   input  logic [`NANORV_XLEN-1:0] rs2_data,
   output logic [`NANORV_XLEN-1:0] pc,
   output logic [`NANORV_XLEN-1:0] pc_plus4,
   output logic                    halted
);

   logic [`NANORV_XLEN-1:0] pc_next;
   logic [`NANORV_XLEN-1:0] target;
   logic                    taken;

   assign pc_plus4 = pc + `NANORV_XLEN'(4);
   // Shared adder for branch and JAL targets
   assign target = pc + ctrl.imm;

   // Branch resolution on register operands
   always_comb begin
      case (ctrl.branch_cond)
         BR_EQ:   taken = (rs1_data == rs2_data);
         BR_NE:   taken = (rs1_data != rs2_data);
         BR_LT:   taken = ($signed(rs1_data) < $signed(rs2_data));
         default: taken = ($signed(rs1_data) >= $signed(rs2_data));
      endcase
   end

   always_comb begin
      case (ctrl.pc_next_sel)
         PC_NEXT_BRANCH: pc_next = taken ? target : pc_plus4;
         PC_NEXT_JAL:    pc_next = target;
         // JALR target with bit 0 dropped
         PC_NEXT_JALR:   pc_next = {alu_result[`NANORV_XLEN-1:1], 1'b0};
         default:        pc_next = pc_plus4;
      endcase
   end

   // Illegal word freezes the PC at once; halted follows at the edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc     <= `NANORV_RESET_PC;
         halted <= 1'b0;
      end else begin
         halted <= halted | ctrl.illegal_instruction;
         if (!halted && !ctrl.illegal_instruction)
            pc <= pc_next;
      end
   end

   // Catches misaligned JALR or branch targets reaching the PC
   a_pc_aligned : assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

// File: hw/nanorv_ctrl_if.sv
`timescale 1ns/100ps
`include "nanorv_config.svh"

interface nanorv_ctrl_if
   import nanorv_pkg::*;
();

   // Decoded controls, valid in the same cycle as the instruction
   pc_next_sel_e        pc_next_sel;
   branch_cond_e        branch_cond;
   alu_op_e             alu_op_sel;
   alu_porta_sel_e      alu_porta_sel;
   alu_portb_sel_e      alu_portb_sel;
   regfile_source_sel_e regfile_source_sel;
   logic                regfile_write;
   logic                datamem_read;
   logic                datamem_write;
   // Register indices and sign-extended immediate
   logic [$clog2(`NANORV_NUM_REGS)-1:0] rd;
   logic [$clog2(`NANORV_NUM_REGS)-1:0] rs1;
   logic [$clog2(`NANORV_NUM_REGS)-1:0] rs2;
   logic [`NANORV_XLEN-1:0]             imm;
   logic                                illegal_instruction;

   modport dec (output pc_next_sel, branch_cond, alu_op_sel, alu_porta_sel, alu_portb_sel,
                output regfile_source_sel, regfile_write, datamem_read, datamem_write,
                output rd, rs1, rs2, imm, illegal_instruction);
   modport fetch (input pc_next_sel, branch_cond, imm, illegal_instruction);
   modport exec (input alu_op_sel, alu_porta_sel, alu_portb_sel, imm);
   modport lsu (input regfile_source_sel, datamem_read, datamem_write);

endinterface

// File: hw/nanorv_pkg.sv
package nanorv_pkg;

   // RV32I major opcodes, subset handled by the core
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_BRANCH = 7'b1100011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011
   } opcode_e;

   // ALU operations
   typedef enum logic [3:0] {
      ALU_NOP,
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_SRL,
      ALU_SRA,
      ALU_PASS_B
   } alu_op_e;

   // Next PC source
   typedef enum logic [1:0] {
      PC_NEXT_PLUS4,
      PC_NEXT_BRANCH,
      PC_NEXT_JAL,
      PC_NEXT_JALR
   } pc_next_sel_e;

   // Branch condition, LT and GE are signed
   typedef enum logic [1:0] {
      BR_EQ,
      BR_NE,
      BR_LT,
      BR_GE
   } branch_cond_e;

   typedef enum logic {PORTA_RS1, PORTA_PC} alu_porta_sel_e;
   typedef enum logic {PORTB_RS2, PORTB_IMM} alu_portb_sel_e;

   // Register file write-back source
   typedef enum logic [1:0] {
      RF_SRC_ALU,
      RF_SRC_MEM,
      RF_SRC_PC_PLUS4
   } regfile_source_sel_e;

endpackage

// File: include/nanorv_config.svh
`ifndef NANORV_CONFIG_SVH
`define NANORV_CONFIG_SVH

// Data path and address width
`define NANORV_XLEN 32

// Address of the first fetch out of reset
`define NANORV_RESET_PC 32'h0000_0000

// Architectural register count, x0 included
`define NANORV_NUM_REGS 32

// Data memory depth in 32-bit words
`define NANORV_DMEM_WORDS 64

`endif
